/* tb.f */
+incdir+common
common/isa_pkg.sv
common/exec_pkg.sv
design/issue_stage.sv
design/reg_file.sv
alu/alu.sv
alu/exec_stage.sv
design/cpu_exec_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* run.sh */
#!/bin/sh
# build and run the execute slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f tb.f --top-module tb_top -o sim_tb_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" sim.log; then
  exit 0
else
  exit 1
fi

/* testbench/tb_top.sv */
`default_nettype none

`include "cpu_macros.svh"

module tb_top;

  localparam int n_random    = 200;
  localparam int n_chain     = 40;
  // worst case per phase; a random gap is at most three idle cycles
  localparam int test_cycles = 17 + 45 + 4 * n_random + 48 + n_chain + 6 + 12 + 4;
  localparam int cycle_limit = test_cycles + 50;

  logic                            clk;
  logic                            rst_n;
  logic                            instr_valid;
  logic [15:0]                     instr;
  logic                            result_valid;
  logic [`WORD_WIDTH-1:0]          result;
  logic [$clog2(`REG_COUNT)-1:0]   result_dest;
  logic                            err;
  logic [1:0]                      test_id;
  logic [1:0]                      phase;
  int                              mismatch_count;
  int                              protocol_count;
  int                              issued_count;
  int                              retired_count;
  int                              cycle_count = 0;
  int                              seed;
  logic [15:0]                     word;
  logic [3:0]                      dst;
  logic [3:0]                      prev;

  cpu_exec_top dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .result_valid (result_valid),
    .result       (result),
    .result_dest  (result_dest),
    .err          (err)
  );

  tb_checker checker_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .test_id        (test_id),
    .result_valid   (result_valid),
    .result         (result),
    .result_dest    (result_dest),
    .err            (err),
    .mismatch_total (mismatch_count),
    .protocol_total (protocol_count),
    .issued_total   (issued_count),
    .retired_total  (retired_count)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  function automatic int rand_below(input int limit);
    return int'($unsigned($random(seed)) % limit);
  endfunction

  function automatic logic [15:0] encode(input logic [3:0] opc, input logic [3:0] rd,
                                         input logic [3:0] rs, input logic [3:0] rt);
    return {opc, rd, rs, rt};
  endfunction

  // one instruction sampled at the next rising edge, tagged with its phase
  task automatic send(input logic [15:0] instr_word);
    @(negedge clk);
    instr_valid = 1'b1;
    instr       = instr_word;
    test_id     = phase;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      instr_valid = 1'b0;
      instr       = '0;
    end
  endtask

  initial begin
    seed        = 95;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    test_id     = 2'd0;
    phase       = 2'd0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // corner values first, then random words
    phase = 2'd0;
    for (int r = 1; r < `REG_COUNT; r++) begin
      case (r)
        1:       word = 16'h7fff;
        2:       word = 16'h8000;
        3:       word = 16'h0001;
        4:       word = 16'hffff;
        default: word = 16'($random(seed));
      endcase
      send(encode(isa_pkg::op_llb, 4'(r), word[7:4], word[3:0]));
      send(encode(isa_pkg::op_lhb, 4'(r), word[15:12], word[11:8]));
      send(encode(isa_pkg::op_xor, 4'd0, 4'(r), 4'd0));
    end

    phase = 2'd1;
    repeat (n_random) begin
      send(encode(4'(rand_below(10)), 4'(rand_below(16)), 4'(rand_below(16)),
                  4'(rand_below(16))));
      if (rand_below(4) == 0) begin
        idle(1 + rand_below(3));
      end
    end
    // every shift amount for each shift op
    for (int sh = 0; sh < 16; sh++) begin
      send(encode(isa_pkg::op_sll, 4'(1 + rand_below(15)), 4'(1 + rand_below(15)), 4'(sh)));
      send(encode(isa_pkg::op_sra, 4'(1 + rand_below(15)), 4'(1 + rand_below(15)), 4'(sh)));
      send(encode(isa_pkg::op_ror, 4'(1 + rand_below(15)), 4'(1 + rand_below(15)), 4'(sh)));
    end

    // each op reads the previous destination
    phase = 2'd2;
    prev  = 4'd1;
    repeat (n_chain) begin
      dst = 4'(rand_below(16));
      send(encode(4'(rand_below(8)), dst, prev, prev));
      prev = dst;
    end
    send(encode(isa_pkg::op_llb, 4'd0, 4'ha, 4'h5));
    send(encode(isa_pkg::op_xor, 4'd1, 4'd0, 4'd0));
    send(encode(isa_pkg::op_llb, 4'd7, 4'h3, 4'hc));
    send(encode(isa_pkg::op_lhb, 4'd7, 4'h9, 4'h1));
    send(encode(isa_pkg::op_add, 4'd8, 4'd7, 4'd7));

    // read the destination back right after each illegal op
    phase = 2'd3;
    for (int o = 10; o < 16; o++) begin
      dst = 4'(1 + rand_below(15));
      send(encode(4'(o), dst, 4'(rand_below(16)), 4'(rand_below(16))));
      send(encode(isa_pkg::op_xor, 4'd0, dst, 4'd0));
    end

    idle(1);
    wait (issued_count == retired_count);
    @(negedge clk);
    $display("errors: %0d total, %0d mismatches, %0d protocol",
             mismatch_count + protocol_count, mismatch_count, protocol_count);
    if (mismatch_count + protocol_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles, %0d results still outstanding",
               cycle_count, issued_count - retired_count);
      $display("test failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_checker.sv */
`default_nettype none

`include "cpu_macros.svh"

module tb_checker (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic                            instr_valid,
  input  wire logic [15:0]                     instr,
  input  wire logic [1:0]                      test_id,
  input  wire logic                            result_valid,
  input  wire logic [`WORD_WIDTH-1:0]          result,
  input  wire logic [$clog2(`REG_COUNT)-1:0]   result_dest,
  input  wire logic                            err,
  output int                                   mismatch_total,
  output int                                   protocol_total,
  output int                                   issued_total,
  output int                                   retired_total
);

  logic [15:0] model_regs [`REG_COUNT];
  logic [15:0] exp_result_q [$];
  logic        exp_err_q [$];
  logic [3:0]  exp_dest_q [$];
  logic [1:0]  test_q [$];
  int          due_q [$];
  int          cycle;
  logic        checking;
  int          mismatch_count;
  int          protocol_count;
  int          issued_count;
  int          retired_count;

  assign mismatch_total = mismatch_count;
  assign protocol_total = protocol_count;
  assign issued_total   = issued_count;
  assign retired_total  = retired_count;

  function automatic string test_name(input logic [1:0] id);
    case (id)
      2'd0:    return "byte_loads";
      2'd1:    return "random_mix";
      2'd2:    return "dep_chains";
      default: return "illegal_ops";
    endcase
  endfunction

  // expected {err, result} for one operation
  function automatic logic [16:0] model_alu(input logic [3:0] opc, input logic [15:0] a,
                                            input logic [15:0] b);
    int          sum;
    int          nib;
    logic [31:0] dbl;
    logic [15:0] res;
    logic        bad;
    bad = 1'b0;
    res = '0;
    case (opc)
      isa_pkg::op_add, isa_pkg::op_sub: begin
        if (opc == isa_pkg::op_add) begin
          sum = int'($signed(a)) + int'($signed(b));
        end else begin
          sum = int'($signed(a)) - int'($signed(b));
        end
        if (sum > 32767) begin
          res = 16'h7fff;
          bad = 1'b1;
        end else if (sum < -32768) begin
          res = 16'h8000;
          bad = 1'b1;
        end else begin
          res = sum[15:0];
        end
      end
      isa_pkg::op_xor: res = a ^ b;
      isa_pkg::op_red: begin
        sum = int'($signed(a[7:0])) + int'($signed(a[15:8]))
            + int'($signed(b[7:0])) + int'($signed(b[15:8]));
        res = sum[15:0];
      end
      isa_pkg::op_sll: res = a << b[3:0];
      isa_pkg::op_sra: res = $signed(a) >>> b[3:0];
      isa_pkg::op_ror: begin
        dbl = {a, a} >> b[3:0];
        res = dbl[15:0];
      end
      isa_pkg::op_paddsb: begin
        for (int n = 0; n < 4; n++) begin
          nib = int'($signed(a[4*n +: 4])) + int'($signed(b[4*n +: 4]));
          if (nib > 7) begin
            res[4*n +: 4] = 4'h7;
          end else if (nib < -8) begin
            res[4*n +: 4] = 4'h8;
          end else begin
            res[4*n +: 4] = nib[3:0];
          end
        end
      end
      isa_pkg::op_llb: res = {a[15:8], b[7:0]};
      isa_pkg::op_lhb: res = {b[7:0], a[7:0]};
      default: bad = 1'b1;
    endcase
    return {bad, res};
  endfunction

  task automatic predict();
    logic [3:0]  opc;
    logic [3:0]  rd;
    logic [15:0] a;
    logic [15:0] b;
    logic [16:0] predicted;
    opc = instr[isa_pkg::opcode_msb:isa_pkg::opcode_lsb];
    rd  = instr[isa_pkg::rd_msb:isa_pkg::rd_lsb];
    a   = model_regs[instr[isa_pkg::rs_msb:isa_pkg::rs_lsb]];
    b   = model_regs[instr[isa_pkg::rt_msb:isa_pkg::rt_lsb]];
    case (opc)
      isa_pkg::op_sll, isa_pkg::op_sra, isa_pkg::op_ror: begin
        b = {12'd0, instr[isa_pkg::imm4_msb:isa_pkg::imm4_lsb]};
      end
      isa_pkg::op_llb, isa_pkg::op_lhb: begin
        a = model_regs[rd];
        b = {8'd0, instr[isa_pkg::imm8_msb:isa_pkg::imm8_lsb]};
      end
      default: ;
    endcase
    predicted = model_alu(opc, a, b);
    exp_result_q.push_back(predicted[15:0]);
    exp_err_q.push_back(predicted[16]);
    exp_dest_q.push_back(rd);
    test_q.push_back(test_id);
    due_q.push_back(cycle + 1);
    issued_count++;
    // saturated results are still written, illegal ones are not
    if (opc <= 4'd9 && rd != 4'd0) begin
      model_regs[rd] = predicted[15:0];
    end
  endtask

  task automatic drop_front();
    void'(exp_result_q.pop_front());
    void'(exp_err_q.pop_front());
    void'(exp_dest_q.pop_front());
    void'(test_q.pop_front());
    void'(due_q.pop_front());
    retired_count++;
  endtask

  task automatic compare_value(input string name, input string field,
                               input logic [15:0] expected, input logic [15:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s %s: expected %h actual %h", name, field, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic check_outputs();
    string name;
    if (due_q.size() > 0 && due_q[0] < cycle) begin
      $display("%s: result_valid never came for the instruction due in cycle %0d",
               test_name(test_q[0]), due_q[0]);
      protocol_count++;
      drop_front();
    end
    if (result_valid) begin
      if (due_q.size() == 0 || due_q[0] != cycle) begin
        $display("result_valid in cycle %0d without an instruction due then", cycle);
        protocol_count++;
      end else begin
        name = test_name(test_q[0]);
        compare_value(name, "result", exp_result_q[0], result);
        compare_value(name, "err", {15'd0, exp_err_q[0]}, {15'd0, err});
        compare_value(name, "dest", {12'd0, exp_dest_q[0]}, {12'd0, result_dest});
        drop_front();
      end
    end
  endtask

  // inputs taken at the rising edge, registered outputs at the falling edge
  initial begin
    mismatch_count = 0;
    protocol_count = 0;
    issued_count   = 0;
    retired_count  = 0;
    cycle          = 0;
    checking       = 1'b0;
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        checking = 1'b0;
        cycle    = 0;
        for (int i = 0; i < `REG_COUNT; i++) begin
          model_regs[i] = '0;
        end
      end else begin
        checking = 1'b1;
        cycle++;
        if (instr_valid) begin
          predict();
        end
      end
      @(negedge clk);
      if (checking) begin
        check_outputs();
      end
    end
  end

endmodule

`default_nettype wire

/* design/cpu_exec_top.sv */
`default_nettype none

`include "cpu_macros.svh"

module cpu_exec_top (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic                            instr_valid,
  input  wire logic [15:0]                     instr,
  output logic                                 result_valid,
  output logic      [`WORD_WIDTH-1:0]          result,
  output logic      [$clog2(`REG_COUNT)-1:0]   result_dest,
  output logic                                 err
);

  logic [$clog2(`REG_COUNT)-1:0] rd_addr_a;
  logic [$clog2(`REG_COUNT)-1:0] rd_addr_b;
  logic [`WORD_WIDTH-1:0]        rd_data_a;
  logic [`WORD_WIDTH-1:0]        rd_data_b;
  logic                          fwd_en;
  logic [$clog2(`REG_COUNT)-1:0] fwd_addr;
  logic [`WORD_WIDTH-1:0]        alu_result;
  logic                          op_valid;
  exec_pkg::exec_op_t            op;
  logic                          wb_en;
  logic [$clog2(`REG_COUNT)-1:0] wb_addr;
  logic [`WORD_WIDTH-1:0]        wb_data;

  issue_stage issue_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rd_addr_a   (rd_addr_a),
    .rd_addr_b   (rd_addr_b),
    .rd_data_a   (rd_data_a),
    .rd_data_b   (rd_data_b),
    .fwd_en      (fwd_en),
    .fwd_addr    (fwd_addr),
    .fwd_data    (alu_result),
    .op_valid    (op_valid),
    .op          (op)
  );

  reg_file reg_file_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wb_en     (wb_en),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data)
  );

  exec_stage exec_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_valid     (op_valid),
    .op           (op),
    .alu_result   (alu_result),
    .fwd_en       (fwd_en),
    .fwd_addr     (fwd_addr),
    .result_valid (result_valid),
    .result       (result),
    .result_dest  (result_dest),
    .err          (err),
    .wb_en        (wb_en),
    .wb_addr      (wb_addr),
    .wb_data      (wb_data)
  );

endmodule

`default_nettype wire

/* alu/exec_stage.sv */
`default_nettype none

`include "cpu_macros.svh"

module exec_stage (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic                            op_valid,
  input  wire exec_pkg::exec_op_t              op,
  output logic      [`WORD_WIDTH-1:0]          alu_result,
  output logic                                 fwd_en,
  output logic      [$clog2(`REG_COUNT)-1:0]   fwd_addr,
  output logic                                 result_valid,
  output logic      [`WORD_WIDTH-1:0]          result,
  output logic      [$clog2(`REG_COUNT)-1:0]   result_dest,
  output logic                                 err,
  output logic                                 wb_en,
  output logic      [$clog2(`REG_COUNT)-1:0]   wb_addr,
  output logic      [`WORD_WIDTH-1:0]          wb_data
);

  logic op_legal;
  logic alu_err;

  alu alu_i (
    .aluop   (op.opcode),
    .alu_in1 (op.operand_a),
    .alu_in2 (op.operand_b),
    .alu_out (alu_result),
    .err     (alu_err)
  );

  assign op_legal = (op.opcode <= isa_pkg::op_lhb);

  // write lands on the same edge as the result registers
  assign wb_en   = op_valid && op_legal && (op.dest != '0);
  assign wb_addr = op.dest;
  assign wb_data = alu_result;

  // in-flight write seen by the next issue
  assign fwd_en   = wb_en;
  assign fwd_addr = op.dest;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
      err          <= 1'b0;
    end else begin
      result_valid <= op_valid;
      err          <= op_valid && alu_err;
    end
  end

  always_ff @(posedge clk) begin
    if (op_valid) begin
      result      <= alu_result;
      result_dest <= op.dest;
    end
  end

  a_illegal_zero: assert property (@(posedge clk) disable iff (!rst_n)
    op_valid && !op_legal |=> result_valid && err && (result == '0));

endmodule

`default_nettype wire

/* alu/alu.sv */
`default_nettype none

`include "cpu_macros.svh"

module alu (
  input  wire isa_pkg::opcode_t           aluop,
  input  wire logic [`WORD_WIDTH-1:0]     alu_in1,
  input  wire logic [`WORD_WIDTH-1:0]     alu_in2,
  output logic      [`WORD_WIDTH-1:0]     alu_out,
  output logic                            err
);

  localparam int msb          = `WORD_WIDTH - 1;
  localparam int shamt_width  = $clog2(`WORD_WIDTH);
  localparam int nibble_count = `WORD_WIDTH / 4;
  localparam int byte_count   = `WORD_WIDTH / 8;

  localparam logic [`WORD_WIDTH-1:0] max_pos = {1'b0, {msb{1'b1}}};
  localparam logic [`WORD_WIDTH-1:0] max_neg = {1'b1, {msb{1'b0}}};

  logic [`WORD_WIDTH-1:0] sum;
  logic [`WORD_WIDTH-1:0] diff;
  logic                   add_ovf;
  logic                   sub_ovf;
  logic [`WORD_WIDTH-1:0] add_sat;
  logic [`WORD_WIDTH-1:0] sub_sat;
  logic [shamt_width-1:0] shamt;
  logic [`WORD_WIDTH-1:0] sll_val;
  logic [`WORD_WIDTH-1:0] sra_val;
  logic [`WORD_WIDTH-1:0] ror_val;
  logic [3:0]             nib_a;
  logic [3:0]             nib_b;
  logic [3:0]             nib_s;
  logic [`WORD_WIDTH-1:0] paddsb_val;
  logic [`WORD_WIDTH-1:0] red_val;

  // signed overflow from operand and result signs
  assign sum     = alu_in1 + alu_in2;
  assign diff    = alu_in1 - alu_in2;
  assign add_ovf = (alu_in1[msb] == alu_in2[msb]) && (sum[msb] != alu_in1[msb]);
  assign sub_ovf = (alu_in1[msb] != alu_in2[msb]) && (diff[msb] != alu_in1[msb]);
  assign add_sat = add_ovf ? (alu_in1[msb] ? max_neg : max_pos) : sum;
  assign sub_sat = sub_ovf ? (alu_in1[msb] ? max_neg : max_pos) : diff;

  // log shifter with one stage per bit of imm4
  assign shamt = alu_in2[shamt_width-1:0];

  always_comb begin
    sll_val = alu_in1;
    sra_val = alu_in1;
    ror_val = alu_in1;
    for (int i = 0; i < shamt_width; i++) begin
      if (shamt[i]) begin
        sll_val = sll_val << (1 << i);
        sra_val = $signed(sra_val) >>> (1 << i);
        ror_val = (ror_val >> (1 << i)) | (ror_val << (`WORD_WIDTH - (1 << i)));
      end
    end
  end

  // each nibble saturates on its own
  always_comb begin
    for (int n = 0; n < nibble_count; n++) begin
      nib_a = alu_in1[4*n +: 4];
      nib_b = alu_in2[4*n +: 4];
      nib_s = nib_a + nib_b;
      if (nib_a[3] == nib_b[3] && nib_s[3] != nib_a[3]) begin
        paddsb_val[4*n +: 4] = nib_a[3] ? 4'h8 : 4'h7;
      end else begin
        paddsb_val[4*n +: 4] = nib_s;
      end
    end
  end

  // sum of all signed bytes fits without overflow
  always_comb begin
    red_val = '0;
    for (int k = 0; k < byte_count; k++) begin
      red_val = red_val + {{(`WORD_WIDTH-8){alu_in1[8*k+7]}}, alu_in1[8*k +: 8]};
      red_val = red_val + {{(`WORD_WIDTH-8){alu_in2[8*k+7]}}, alu_in2[8*k +: 8]};
    end
  end

  always_comb begin
    err = 1'b0;
    case (aluop)
      isa_pkg::op_add: begin
        alu_out = add_sat;
        err     = add_ovf;
      end
      isa_pkg::op_sub: begin
        alu_out = sub_sat;
        err     = sub_ovf;
      end
      isa_pkg::op_xor:    alu_out = alu_in1 ^ alu_in2;
      isa_pkg::op_red:    alu_out = red_val;
      isa_pkg::op_sll:    alu_out = sll_val;
      isa_pkg::op_sra:    alu_out = sra_val;
      isa_pkg::op_ror:    alu_out = ror_val;
      isa_pkg::op_paddsb: alu_out = paddsb_val;
      isa_pkg::op_llb:    alu_out = {alu_in1[msb:8], alu_in2[7:0]};
      isa_pkg::op_lhb:    alu_out = {alu_in2[7:0], alu_in1[7:0]};
      default: begin
        alu_out = '0;
        err     = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/reg_file.sv */
`default_nettype none

`include "cpu_macros.svh"

module reg_file (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic [$clog2(`REG_COUNT)-1:0]   rd_addr_a,
  input  wire logic [$clog2(`REG_COUNT)-1:0]   rd_addr_b,
  output logic      [`WORD_WIDTH-1:0]          rd_data_a,
  output logic      [`WORD_WIDTH-1:0]          rd_data_b,
  input  wire logic                            wb_en,
  input  wire logic [$clog2(`REG_COUNT)-1:0]   wb_addr,
  input  wire logic [`WORD_WIDTH-1:0]          wb_data
);

  logic [`WORD_WIDTH-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // r0 is hardwired
  assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
  assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

  // execute must filter r0 writes
  a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
    wb_en |-> wb_addr != '0);

endmodule

`default_nettype wire

/* design/issue_stage.sv */
`default_nettype none

`include "cpu_macros.svh"

module issue_stage (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic                            instr_valid,
  input  wire logic [15:0]                     instr,
  output logic      [$clog2(`REG_COUNT)-1:0]   rd_addr_a,
  output logic      [$clog2(`REG_COUNT)-1:0]   rd_addr_b,
  input  wire logic [`WORD_WIDTH-1:0]          rd_data_a,
  input  wire logic [`WORD_WIDTH-1:0]          rd_data_b,
  input  wire logic                            fwd_en,
  input  wire logic [$clog2(`REG_COUNT)-1:0]   fwd_addr,
  input  wire logic [`WORD_WIDTH-1:0]          fwd_data,
  output logic                                 op_valid,
  output exec_pkg::exec_op_t                   op
);

  isa_pkg::opcode_t                opcode;
  logic [$clog2(`REG_COUNT)-1:0]   rd;
  logic [$clog2(`REG_COUNT)-1:0]   rs;
  logic [$clog2(`REG_COUNT)-1:0]   rt;
  logic [3:0]                      imm4;
  logic [7:0]                      imm8;
  logic                            is_byte_load;
  logic [`WORD_WIDTH-1:0]          src_a;
  logic [`WORD_WIDTH-1:0]          src_b;
  logic [`WORD_WIDTH-1:0]          operand_b;

  assign opcode = isa_pkg::opcode_t'(instr[isa_pkg::opcode_msb:isa_pkg::opcode_lsb]);
  assign rd     = instr[isa_pkg::rd_msb:isa_pkg::rd_lsb];
  assign rs     = instr[isa_pkg::rs_msb:isa_pkg::rs_lsb];
  assign rt     = instr[isa_pkg::rt_msb:isa_pkg::rt_lsb];
  assign imm4   = instr[isa_pkg::imm4_msb:isa_pkg::imm4_lsb];
  assign imm8   = instr[isa_pkg::imm8_msb:isa_pkg::imm8_lsb];

  // llb/lhb keep the other byte of rd
  assign is_byte_load = (opcode == isa_pkg::op_llb) || (opcode == isa_pkg::op_lhb);
  assign rd_addr_a    = is_byte_load ? rd : rs;
  assign rd_addr_b    = rt;

  // bypass the value still in execute; fwd_en is never set for r0
  assign src_a = (fwd_en && fwd_addr == rd_addr_a) ? fwd_data : rd_data_a;
  assign src_b = (fwd_en && fwd_addr == rd_addr_b) ? fwd_data : rd_data_b;

  always_comb begin
    case (opcode)
      isa_pkg::op_sll,
      isa_pkg::op_sra,
      isa_pkg::op_ror: operand_b = {{(`WORD_WIDTH-4){1'b0}}, imm4};
      isa_pkg::op_llb,
      isa_pkg::op_lhb: operand_b = {{(`WORD_WIDTH-8){1'b0}}, imm8};
      default:         operand_b = src_b;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      op_valid <= 1'b0;
    end else begin
      op_valid <= instr_valid;
    end
  end

  // decoded payload qualified by op_valid
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      op.opcode    <= opcode;
      op.dest      <= rd;
      op.operand_a <= src_a;
      op.operand_b <= operand_b;
    end
  end

  a_instr_known: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid |-> !$isunknown(instr));

endmodule

`default_nettype wire

/* common/exec_pkg.sv */
`default_nettype none

`include "cpu_macros.svh"

package exec_pkg;

  // decoded operation handed from issue to execute
  typedef struct packed {
    isa_pkg::opcode_t                 opcode;
    // write-back register
    logic [$clog2(`REG_COUNT)-1:0]    dest;
    // rs, or rd for byte loads
    logic [`WORD_WIDTH-1:0]           operand_a;
    // rt or a zero-extended immediate
    logic [`WORD_WIDTH-1:0]           operand_b;
  } exec_op_t;

endpackage

`default_nettype wire

/* common/isa_pkg.sv */
`default_nettype none

`include "cpu_macros.svh"

package isa_pkg;

  // values 10 to 15 are illegal
  typedef enum logic [`OPCODE_WIDTH-1:0] {
    op_add    = 4'd0,
    op_sub    = 4'd1,
    op_xor    = 4'd2,
    op_red    = 4'd3,
    op_sll    = 4'd4,
    op_sra    = 4'd5,
    op_ror    = 4'd6,
    op_paddsb = 4'd7,
    op_llb    = 4'd8,
    op_lhb    = 4'd9
  } opcode_t;

  // instruction word fields
  localparam int opcode_msb = 15;
  localparam int opcode_lsb = 12;
  localparam int rd_msb     = 11;
  localparam int rd_lsb     = 8;
  localparam int rs_msb     = 7;
  localparam int rs_lsb     = 4;
  localparam int rt_msb     = 3;
  localparam int rt_lsb     = 0;
  // immediates overlap the register fields
  localparam int imm4_msb   = 3;
  localparam int imm4_lsb   = 0;
  localparam int imm8_msb   = 7;
  localparam int imm8_lsb   = 0;

endpackage

`default_nettype wire

/* common/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath word width
`define WORD_WIDTH 16

// architectural registers with r0 hardwired to zero
`define REG_COUNT 16

// opcode field of the instruction word
`define OPCODE_WIDTH 4

`endif
